// File: hw/rs_cfg.svh
/*
 * Sizing for the reservation station.
 * Entry counts per functional-unit class, in entry order
 * load, store, branch, multiply, ALU, plus the physical register count.
 * Included by the package and by any file that sizes arrays by entry.
 */
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// Entries per class
`define RS_NUM_LD     1
`define RS_NUM_ST     1
`define RS_NUM_BR     1
`define RS_NUM_MULT   2
`define RS_NUM_ALU    3

// Whole station, sum of the classes
`define RS_NUM_ENTRIES (`RS_NUM_LD + `RS_NUM_ST + `RS_NUM_BR + `RS_NUM_MULT + `RS_NUM_ALU)

// Physical register file size, sets the tag width
`define RS_NUM_PR     64

`endif

// File: hw/rs_pkg.sv
/*
 * Shared types for the reservation station.
 * Tags, class and function codes, entry index and entry vector,
 * plus lookups that map a class to its fixed entry range.
 */
`include "rs_cfg.svh"

package rs_pkg;

  // Physical register tag
  typedef logic [$clog2(`RS_NUM_PR)-1:0] tag_t;
  // Functional-unit class code
  typedef logic [2:0] fu_t;
  // ALU function, passed through untouched
  typedef logic [4:0] alu_func_t;
  // Entry index and one-bit-per-entry vector
  typedef logic [$clog2(`RS_NUM_ENTRIES)-1:0] entry_idx_t;
  typedef logic [`RS_NUM_ENTRIES-1:0] entry_vec_t;

  // Class codes
  localparam fu_t FU_ALU  = 3'd0;
  localparam fu_t FU_ST   = 3'd1;
  localparam fu_t FU_LD   = 3'd2;
  localparam fu_t FU_MULT = 3'd3;
  localparam fu_t FU_BR   = 3'd4;

  // First entry of a class; unknown codes fall to ALU
  function automatic entry_idx_t class_base(input fu_t fu);
    case (fu)
      FU_LD:   return entry_idx_t'(0);
      FU_ST:   return entry_idx_t'(`RS_NUM_LD);
      FU_BR:   return entry_idx_t'(`RS_NUM_LD + `RS_NUM_ST);
      FU_MULT: return entry_idx_t'(`RS_NUM_LD + `RS_NUM_ST + `RS_NUM_BR);
      default: return entry_idx_t'(`RS_NUM_LD + `RS_NUM_ST + `RS_NUM_BR + `RS_NUM_MULT);
    endcase
  endfunction

  // Number of entries owned by a class
  function automatic int unsigned class_count(input fu_t fu);
    case (fu)
      FU_LD:   return `RS_NUM_LD;
      FU_ST:   return `RS_NUM_ST;
      FU_BR:   return `RS_NUM_BR;
      FU_MULT: return `RS_NUM_MULT;
      default: return `RS_NUM_ALU;
    endcase
  endfunction

endpackage

// File: hw/rs_if.sv
/*
 * Stage-to-stage bundles of the reservation station.
 * rs_alloc_if is the entry write from dispatch into the station.
 * rs_issue_if exposes the station contents to select and returns
 * the clear of the issued entry.
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

////////////////////////////////////////
// Allocation write
////////////////////////////////////////
interface rs_alloc_if;
  import rs_pkg::*;

  logic      we;
  entry_idx_t idx;
  fu_t       fu;
  alu_func_t func;
  tag_t      dest;
  tag_t      t1;
  logic      t1_ready;
  tag_t      t2;
  logic      t2_ready;

  modport dispatch (output we, idx, fu, func, dest, t1, t1_ready, t2, t2_ready);
  modport station  (input  we, idx, fu, func, dest, t1, t1_ready, t2, t2_ready);
endinterface

////////////////////////////////////////
// Station view for select, clear back
////////////////////////////////////////
interface rs_issue_if;
  import rs_pkg::*;

  // Busy with both sources ready
  entry_vec_t ready;
  // Per-entry payload
  fu_t       [`RS_NUM_ENTRIES-1:0] fu;
  alu_func_t [`RS_NUM_ENTRIES-1:0] func;
  tag_t      [`RS_NUM_ENTRIES-1:0] dest;
  tag_t      [`RS_NUM_ENTRIES-1:0] t1;
  tag_t      [`RS_NUM_ENTRIES-1:0] t2;
  // Free the issued entry at the edge
  logic       clr;
  entry_idx_t clr_idx;

  modport station (output ready, fu, func, dest, t1, t2, input  clr, clr_idx);
  modport select  (input  ready, fu, func, dest, t1, t2, output clr, clr_idx);
endinterface

// File: hw/rs_dispatch.sv
/*
 * Dispatch and allocate stage.
 * Finds the lowest free entry in the class range of the incoming
 * instruction, flags rs_hazard when the class is full, and forms the
 * station write with the same-cycle CDB bypass on both sources.
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_dispatch (
  input  logic               dispatch_en,
  input  rs_pkg::fu_t        disp_fu,
  input  rs_pkg::alu_func_t  disp_func,
  input  rs_pkg::tag_t       disp_dest,
  input  rs_pkg::tag_t       disp_t1,
  input  logic               disp_t1_ready,
  input  rs_pkg::tag_t       disp_t2,
  input  logic               disp_t2_ready,
  input  logic               complete_en,
  input  rs_pkg::tag_t       cdb_tag,
  input  rs_pkg::entry_vec_t busy,
  output logic               rs_hazard,
  rs_alloc_if.dispatch       alloc
);
  import rs_pkg::*;

  fu_t         cls;
  entry_idx_t  base;
  int unsigned count;
  entry_vec_t  class_mask;
  entry_vec_t  free_vec;
  logic        found;
  entry_idx_t  free_idx;

  // Codes past BR are handled as ALU
  assign cls   = (disp_fu > FU_BR) ? FU_ALU : disp_fu;
  assign base  = class_base(cls);
  assign count = class_count(cls);

  // Entries owned by this class
  always_comb begin
    for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
      class_mask[i] = (i >= int'(base)) && (i < int'(base) + int'(count));
    end
  end

  // Busy now means taken even if it issues this cycle
  assign free_vec = class_mask & ~busy;

  // Lowest free entry wins
  always_comb begin
    found    = 1'b0;
    free_idx = base;
    for (int i = `RS_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        found    = 1'b1;
        free_idx = entry_idx_t'(i);
      end
    end
  end

  assign rs_hazard = dispatch_en & ~found;

  ////////////////////////////////////////
  // Station write
  ////////////////////////////////////////
  assign alloc.we   = dispatch_en & found;
  assign alloc.idx  = free_idx;
  assign alloc.fu   = cls;
  assign alloc.func = disp_func;
  assign alloc.dest = disp_dest;
  assign alloc.t1   = disp_t1;
  assign alloc.t2   = disp_t2;
  // Bypass a broadcast landing in the dispatch cycle
  assign alloc.t1_ready = disp_t1_ready | (complete_en && (cdb_tag == disp_t1));
  assign alloc.t2_ready = disp_t2_ready | (complete_en && (cdb_tag == disp_t2));

endmodule

// File: hw/rs_station.sv
/*
 * Reservation station storage.
 * Eight entries with busy and per-source ready bits. Each edge applies
 * the dispatch write, the CDB wakeup on stored sources and the clear of
 * the entry picked by select. Exports busy to dispatch and ready plus
 * payload to select.
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_station (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               complete_en,
  input  rs_pkg::tag_t       cdb_tag,
  output rs_pkg::entry_vec_t busy,
  rs_alloc_if.station        alloc,
  rs_issue_if.station        iss
);
  import rs_pkg::*;

  // Payload of one entry
  typedef struct packed {
    fu_t       fu;
    alu_func_t func;
    tag_t      dest;
    tag_t      t1;
    tag_t      t2;
  } entry_t;

  entry_t     ent [`RS_NUM_ENTRIES];
  entry_vec_t busy_q;
  entry_vec_t t1_rdy;
  entry_vec_t t2_rdy;

  ////////////////////////////////////////
  // Payload, written only on allocation
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
      if (alloc.we && (alloc.idx == entry_idx_t'(i))) begin
        ent[i].fu   <= alloc.fu;
        ent[i].func <= alloc.func;
        ent[i].dest <= alloc.dest;
        ent[i].t1   <= alloc.t1;
        ent[i].t2   <= alloc.t2;
      end
    end
  end

  ////////////////////////////////////////
  // Busy and ready bits
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      busy_q <= '0;
      t1_rdy <= '0;
      t2_rdy <= '0;
    end else begin
      for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
        if (alloc.we && (alloc.idx == entry_idx_t'(i))) begin
          // New entry, bypass already folded in by dispatch
          busy_q[i] <= 1'b1;
          t1_rdy[i] <= alloc.t1_ready;
          t2_rdy[i] <= alloc.t2_ready;
        end else begin
          // Issued entry leaves at this edge
          if (iss.clr && (iss.clr_idx == entry_idx_t'(i))) begin
            busy_q[i] <= 1'b0;
          end
          // CDB tag compare on both sources
          if (complete_en && (ent[i].t1 == cdb_tag)) begin
            t1_rdy[i] <= 1'b1;
          end
          if (complete_en && (ent[i].t2 == cdb_tag)) begin
            t2_rdy[i] <= 1'b1;
          end
        end
      end
    end
  end

  assign busy      = busy_q;
  // Candidate for issue
  assign iss.ready = busy_q & t1_rdy & t2_rdy;

  // Flatten payload onto the issue bundle
  always_comb begin
    for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
      iss.fu[i]   = ent[i].fu;
      iss.func[i] = ent[i].func;
      iss.dest[i] = ent[i].dest;
      iss.t1[i]   = ent[i].t1;
      iss.t2[i]   = ent[i].t2;
    end
  end

endmodule

// File: hw/rs_select.sv
/*
 * Select and issue register.
 * Picks the lowest ready entry while en is high, clears it in the
 * station and registers its fields on the issue port for the next cycle.
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_select (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              en,
  rs_issue_if.select        iss,
  output logic              issue_valid,
  output rs_pkg::fu_t       issue_fu,
  output rs_pkg::alu_func_t issue_func,
  output rs_pkg::tag_t      issue_dest,
  output rs_pkg::tag_t      issue_t1,
  output rs_pkg::tag_t      issue_t2
);
  import rs_pkg::*;

  logic       pick_valid;
  entry_idx_t pick_idx;
  logic       fire;

  ////////////////////////////////////////
  // Lowest-index priority picker
  ////////////////////////////////////////
  always_comb begin
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int i = `RS_NUM_ENTRIES - 1; i >= 0; i--) begin
      if (iss.ready[i]) begin
        pick_valid = 1'b1;
        pick_idx   = entry_idx_t'(i);
      end
    end
  end

  // Stall blocks both issue and clear
  assign fire        = en & pick_valid;
  assign iss.clr     = fire;
  assign iss.clr_idx = pick_idx;

  // Valid flag
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= fire;
    end
  end

  // Payload only moves on an issue
  always_ff @(posedge clock) begin
    if (fire) begin
      issue_fu   <= iss.fu[pick_idx];
      issue_func <= iss.func[pick_idx];
      issue_dest <= iss.dest[pick_idx];
      issue_t1   <= iss.t1[pick_idx];
      issue_t2   <= iss.t2[pick_idx];
    end
  end

endmodule

// File: hw/rs_top.sv
/*
 * Reservation station top level.
 * Chains dispatch, station and select; plain ports on the outside,
 * stage bundles inside. issue_valid marks each issued instruction.
 */
`timescale 1ns/1ps

module rs_top (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              en,
  // Dispatch side
  input  logic              dispatch_en,
  input  rs_pkg::fu_t       disp_fu,
  input  rs_pkg::alu_func_t disp_func,
  input  rs_pkg::tag_t      disp_dest,
  input  rs_pkg::tag_t      disp_t1,
  input  logic              disp_t1_ready,
  input  rs_pkg::tag_t      disp_t2,
  input  logic              disp_t2_ready,
  // Completion broadcast
  input  logic              complete_en,
  input  rs_pkg::tag_t      cdb_tag,
  output logic              rs_hazard,
  // Issue port
  output logic              issue_valid,
  output rs_pkg::fu_t       issue_fu,
  output rs_pkg::alu_func_t issue_func,
  output rs_pkg::tag_t      issue_dest,
  output rs_pkg::tag_t      issue_t1,
  output rs_pkg::tag_t      issue_t2
);
  import rs_pkg::*;

  // Occupancy back to dispatch
  entry_vec_t busy;

  rs_alloc_if alloc_bus ();
  rs_issue_if issue_bus ();

  rs_dispatch i_dispatch (
    .dispatch_en   (dispatch_en),
    .disp_fu       (disp_fu),
    .disp_func     (disp_func),
    .disp_dest     (disp_dest),
    .disp_t1       (disp_t1),
    .disp_t1_ready (disp_t1_ready),
    .disp_t2       (disp_t2),
    .disp_t2_ready (disp_t2_ready),
    .complete_en   (complete_en),
    .cdb_tag       (cdb_tag),
    .busy          (busy),
    .rs_hazard     (rs_hazard),
    .alloc         (alloc_bus.dispatch)
  );

  rs_station i_station (
    .clock       (clock),
    .rst_n       (rst_n),
    .complete_en (complete_en),
    .cdb_tag     (cdb_tag),
    .busy        (busy),
    .alloc       (alloc_bus.station),
    .iss         (issue_bus.station)
  );

  rs_select i_select (
    .clock       (clock),
    .rst_n       (rst_n),
    .en          (en),
    .iss         (issue_bus.select),
    .issue_valid (issue_valid),
    .issue_fu    (issue_fu),
    .issue_func  (issue_func),
    .issue_dest  (issue_dest),
    .issue_t1    (issue_t1),
    .issue_t2    (issue_t2)
  );

endmodule

// File: verif/rs_assert.sv
/*
 * Concurrent checks on the reservation station internals.
 * Bound once to the station (allocation side) and once to select
 * (clear and issue side); station_side picks which group is active.
 */
`timescale 1ns/1ps

module rs_assert #(
  parameter bit station_side = 1'b1
) (
  input logic               clock,
  input logic               rst_n,
  input logic               en,
  input rs_pkg::entry_vec_t ready,
  input logic               clr,
  input rs_pkg::entry_idx_t clr_idx,
  input logic               we,
  input rs_pkg::entry_idx_t idx,
  input rs_pkg::entry_vec_t busy,
  input logic               issue_valid
);
  import rs_pkg::*;

  if (station_side) begin : g_station
    // Allocation only lands on a free entry
    a_write_free: assert property (@(posedge clock) disable iff (!rst_n)
      we |-> !busy[idx])
      else $error("allocation write targets busy entry %0d", idx);
  end else begin : g_select
    // Entries below the cleared one
    entry_vec_t below_clr;

    assign below_clr = (entry_vec_t'(1) << clr_idx) - entry_vec_t'(1);

    // Clear goes to the lowest entry that is ready now
    a_clr_ready: assert property (@(posedge clock) disable iff (!rst_n)
      clr |-> ready[clr_idx] && ((ready & below_clr) == '0))
      else $error("clear targets entry %0d which is not the lowest ready", clr_idx);
    // Stall cycle leaves the issue port empty
    a_stall: assert property (@(posedge clock) disable iff (!rst_n)
      !en |=> !issue_valid)
      else $error("issue_valid set after a cycle with en low");
    a_reset: assert property (@(posedge clock) !rst_n |=> !issue_valid)
      else $error("issue_valid set after reset");
  end

endmodule

// File: verif/rs_tb.sv
/*
 * Random testbench for the reservation station.
 * Seeded dispatch, completion and issue-enable stimulus on the falling
 * edge; an entry-level model predicts rs_hazard and the issue port.
 * Ends with a drain that broadcasts every pending tag.
 */
`timescale 1ns/1ps
`include "rs_cfg.svh"

module rs_tb;
  import rs_pkg::*;

  localparam int n_ent       = `RS_NUM_ENTRIES;
  localparam int num_cycles  = 2000;
  localparam int drain_limit = 200;

  logic      clock, rst_n, en, dispatch_en, complete_en, rs_hazard, issue_valid;
  logic      disp_t1_ready, disp_t2_ready;
  fu_t       disp_fu, issue_fu;
  alu_func_t disp_func, issue_func;
  tag_t      disp_dest, disp_t1, disp_t2, cdb_tag, issue_dest, issue_t1, issue_t2;

  // Model entries
  logic      m_busy [n_ent];
  logic      m_r1 [n_ent];
  logic      m_r2 [n_ent];
  fu_t       m_fu [n_ent];
  alu_func_t m_func [n_ent];
  tag_t      m_dest [n_ent];
  tag_t      m_t1 [n_ent];
  tag_t      m_t2 [n_ent];
  // Issue port expected after the last edge
  logic      exp_valid;
  fu_t       exp_fu;
  alu_func_t exp_func;
  tag_t      exp_dest, exp_t1, exp_t2;
  int        seed = 32'h8360;
  int        drain;

  rs_top i_dut (.*);

  bind rs_station rs_assert #(.station_side(1'b1)) i_assert (
    .clock(clock), .rst_n(rst_n), .en(1'b1), .ready('0), .clr(1'b0), .clr_idx('0),
    .we(alloc.we), .idx(alloc.idx), .busy(busy_q), .issue_valid(1'b0));
  bind rs_select rs_assert #(.station_side(1'b0)) i_assert (
    .clock(clock), .rst_n(rst_n), .en(en), .ready(iss.ready), .clr(iss.clr),
    .clr_idx(iss.clr_idx), .we(1'b0), .idx('0), .busy('0), .issue_valid(issue_valid));

  always #2 clock = ~clock;

  ////////////////////////////////////////
  // Reporting and compares
  ////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_fu(input string name, input fu_t got, input fu_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_func(input string name, input alu_func_t got, input alu_func_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Lowest free entry of the class or -1 when full
  function automatic int free_entry(input fu_t fu);
    int lo;
    int hi;
    int pick;
    case (fu)
      FU_LD:   lo = 0;
      FU_ST:   lo = 1;
      FU_BR:   lo = 2;
      FU_MULT: lo = 3;
      default: lo = 5;
    endcase
    // MULT owns two entries and ALU the top three
    hi = (fu == FU_MULT) ? 4 : (lo == 5) ? 7 : lo;
    pick = -1;
    for (int i = hi; i >= lo; i--) begin
      if (!m_busy[i]) pick = i;
    end
    return pick;
  endfunction

  // Class an entry records with unknown codes as ALU
  function automatic fu_t stored_class(input fu_t fu);
    case (fu)
      FU_LD, FU_ST, FU_BR, FU_MULT: return fu;
      default:                      return FU_ALU;
    endcase
  endfunction

  function automatic logic station_empty();
    foreach (m_busy[i]) begin
      if (m_busy[i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic model_step();
    int pick;
    int slot;
    if (!rst_n) begin
      foreach (m_busy[i]) m_busy[i] = 1'b0;
      exp_valid = 1'b0;
      return;
    end
    // Pick and allocate from state before the edge
    pick = -1;
    for (int i = n_ent - 1; i >= 0; i--) begin
      if (en && m_busy[i] && m_r1[i] && m_r2[i]) pick = i;
    end
    slot = dispatch_en ? free_entry(disp_fu) : -1;
    exp_valid = (pick >= 0);
    if (pick >= 0) begin
      exp_fu   = m_fu[pick];
      exp_func = m_func[pick];
      exp_dest = m_dest[pick];
      exp_t1   = m_t1[pick];
      exp_t2   = m_t2[pick];
      m_busy[pick] = 1'b0;
    end
    // Broadcast wakes every stored source with the tag
    for (int i = 0; i < n_ent; i++) begin
      if (complete_en && m_t1[i] == cdb_tag) m_r1[i] = 1'b1;
      if (complete_en && m_t2[i] == cdb_tag) m_r2[i] = 1'b1;
    end
    if (slot >= 0) begin
      m_busy[slot] = 1'b1;
      m_fu[slot]   = stored_class(disp_fu);
      m_func[slot] = disp_func;
      m_dest[slot] = disp_dest;
      m_t1[slot]   = disp_t1;
      m_t2[slot]   = disp_t2;
      // Same-cycle bypass
      m_r1[slot] = disp_t1_ready || (complete_en && cdb_tag == disp_t1);
      m_r2[slot] = disp_t2_ready || (complete_en && cdb_tag == disp_t2);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  function automatic int roll();
    return $unsigned($random(seed)) % 100;
  endfunction

  // Tag some waiting source is blocked on or a random one
  function automatic tag_t pending_tag();
    int start;
    int j;
    start = roll() % n_ent;
    for (int k = 0; k < n_ent; k++) begin
      j = (start + k) % n_ent;
      if (m_busy[j] && !m_r1[j]) return m_t1[j];
      if (m_busy[j] && !m_r2[j]) return m_t2[j];
    end
    return tag_t'($random(seed) & 15);
  endfunction

  task automatic drive_idle();
    en            = 1'b0;
    dispatch_en   = 1'b0;
    disp_fu       = FU_ALU;
    disp_func     = '0;
    disp_dest     = '0;
    disp_t1       = '0;
    disp_t1_ready = 1'b0;
    disp_t2       = '0;
    disp_t2_ready = 1'b0;
    complete_en   = 1'b0;
    cdb_tag       = '0;
  endtask

  task automatic drive_random();
    dispatch_en   = (roll() < 60);
    disp_fu       = fu_t'($random(seed));
    disp_func     = alu_func_t'($random(seed));
    disp_dest     = tag_t'($random(seed));
    // Narrow source range so tags repeat across entries
    disp_t1       = tag_t'($random(seed) & 15);
    disp_t1_ready = (roll() < 50);
    disp_t2       = tag_t'($random(seed) & 15);
    disp_t2_ready = (roll() < 50);
    complete_en   = (roll() < 40);
    cdb_tag       = (roll() < 80) ? pending_tag() : tag_t'($random(seed) & 15);
    en            = (roll() < 85);
  endtask

  task automatic check_outputs();
    check_bit("rs_hazard", rs_hazard, dispatch_en && (free_entry(disp_fu) < 0));
    check_bit("issue_valid", issue_valid, exp_valid);
    if (exp_valid) begin
      check_fu("issue_fu", issue_fu, exp_fu);
      check_func("issue_func", issue_func, exp_func);
      check_tag("issue_dest", issue_dest, exp_dest);
      check_tag("issue_t1", issue_t1, exp_t1);
      check_tag("issue_t2", issue_t2, exp_t2);
    end
  endtask

  // One clock with the model at the rise and compares at the fall
  task automatic run_cycle();
    @(posedge clock);
    model_step();
    @(negedge clock);
    check_outputs();
  endtask

  initial begin
    clock = 1'b0;
    rst_n = 1'b0;
    drive_idle();
    repeat (5) run_cycle();
    rst_n = 1'b1;
    for (int c = 0; c < num_cycles; c++) begin
      drive_random();
      run_cycle();
    end
    // Drain with no dispatch until the station is empty
    drain = 0;
    while (!station_empty() && drain < drain_limit) begin
      drive_idle();
      en          = 1'b1;
      complete_en = 1'b1;
      cdb_tag     = pending_tag();
      run_cycle();
      drain++;
    end
    if (!station_empty() || i_dut.busy !== '0) begin
      abort_run("Station did not empty within the drain timeout");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+hw
hw/rs_pkg.sv
hw/rs_if.sv
hw/rs_dispatch.sv
hw/rs_station.sv
hw/rs_select.sv
hw/rs_top.sv
verif/rs_assert.sv
verif/rs_tb.sv

// File: Makefile
# Verilator build and run of the reservation station testbench
TOOL  := verilator
FLAGS := --binary --timing --assert
TOP   := rs_tb
FLIST := verilog.f
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then exit 1; fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
